// ==== filelist.f ====
+incdir+tb
logic/hsid_pkg.sv
logic/hsid_ctrl_reg.sv
logic/hsid_sequencer.sv
logic/hsid_sq_diff_lane.sv
logic/hsid_mse_combiner.sv
logic/hsid_top.sv
tb/hsid_tb.sv

// ==== logic/hsid_ctrl_reg.sv ====
`timescale 1ns/1ps

module hsid_ctrl_reg (
  input  logic                               clk,
  input  logic                               arst_n,
  input  hsid_pkg::axil_req_t                axil_req,
  output hsid_pkg::axil_rsp_t                axil_rsp,
  output logic                               start,
  output logic                               clear,
  output hsid_pkg::run_cfg_t                 cfg,
  output logic [hsid_pkg::WORD_WIDTH-1:0]    captured_pixel_addr,
  output logic [hsid_pkg::WORD_WIDTH-1:0]    library_pixel_addr,
  input  hsid_pkg::run_status_t              status,
  input  hsid_pkg::mse_result_t              result,
  input  logic                               result_valid
);
  import hsid_pkg::*;

  logic                       aw_seen, w_seen;    // Halves of a pending write
  logic [AXIL_ADDR_WIDTH-1:0] aw_addr_q;
  logic [WORD_WIDTH-1:0]      w_data_q;
  logic [WORD_WIDTH/8-1:0]    w_strb_q;
  logic                       b_valid, r_valid;
  axil_resp_e                 b_resp, r_resp, rd_resp;
  logic [WORD_WIDTH-1:0]      r_data, rd_data;
  logic                       wr_fire;
  mse_result_t                res_q;              // Latched results

  // Byte-lane merge of a write into the old value
  function automatic logic [WORD_WIDTH-1:0] merge(input logic [WORD_WIDTH-1:0] old_val,
                                                  input logic [WORD_WIDTH-1:0] new_val,
                                                  input logic [WORD_WIDTH/8-1:0] strb);
    logic [WORD_WIDTH-1:0] res;
    res = old_val;
    for (int i = 0; i < WORD_WIDTH/8; i++) begin
      if (strb[i]) res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  assign wr_fire = aw_seen && w_seen;  // Both halves in, commit this cycle

  assign axil_rsp.aw_ready = !aw_seen && !b_valid;
  assign axil_rsp.w_ready  = !w_seen && !b_valid;
  assign axil_rsp.b_valid  = b_valid;
  assign axil_rsp.b_resp   = b_resp;
  assign axil_rsp.ar_ready = !r_valid;  // One read outstanding
  assign axil_rsp.r_valid  = r_valid;
  assign axil_rsp.r_data   = r_data;
  assign axil_rsp.r_resp   = r_resp;

  always_ff @(posedge clk) begin
    if (axil_req.aw_valid && axil_rsp.aw_ready) aw_addr_q <= axil_req.aw_addr;
    if (axil_req.w_valid && axil_rsp.w_ready) begin
      w_data_q <= axil_req.w_data;
      w_strb_q <= axil_req.w_strb;
    end
  end

  // Write channel and configuration
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      aw_seen             <= 1'b0;
      w_seen              <= 1'b0;
      b_valid             <= 1'b0;
      b_resp              <= OKAY;
      start               <= 1'b0;
      clear               <= 1'b0;
      cfg                 <= '0;
      captured_pixel_addr <= '0;
      library_pixel_addr  <= '0;
    end else begin
      start <= 1'b0;  // Self-clearing pulses
      clear <= 1'b0;
      if (axil_req.aw_valid && axil_rsp.aw_ready) aw_seen <= 1'b1;
      if (axil_req.w_valid && axil_rsp.w_ready)   w_seen  <= 1'b1;
      if (b_valid && axil_req.b_ready) b_valid <= 1'b0;
      if (wr_fire) begin
        aw_seen <= 1'b0;
        w_seen  <= 1'b0;
        b_valid <= 1'b1;
        b_resp  <= OKAY;
        case (reg_addr_e'(aw_addr_q))
          STATUS: if (w_strb_q[0]) begin
            start <= w_data_q[0] && status.idle;  // No start while busy
            clear <= w_data_q[1];
          end
          LIBRARY_SIZE:
            if (status.idle) cfg.library_size <= HSI_LIBRARY_SIZE_ADDR'(
                merge(WORD_WIDTH'(cfg.library_size), w_data_q, w_strb_q));
            else b_resp <= SLVERR;
          PIXEL_BANDS:
            if (status.idle) cfg.pixel_bands <= HSI_BANDS_ADDR'(
                merge(WORD_WIDTH'(cfg.pixel_bands), w_data_q, w_strb_q));
            else b_resp <= SLVERR;
          CAPTURED_PIXEL_ADDR:
            if (status.idle)
              captured_pixel_addr <= merge(captured_pixel_addr, w_data_q, w_strb_q);
            else b_resp <= SLVERR;
          LIBRARY_PIXEL_ADDR:
            if (status.idle)
              library_pixel_addr <= merge(library_pixel_addr, w_data_q, w_strb_q);
            else b_resp <= SLVERR;
          MSE_MIN_REF, MSE_MIN_VALUE, MSE_MAX_REF, MSE_MAX_VALUE: ;  // Read only
          default: b_resp <= SLVERR;
        endcase
      end
    end
  end

  // Results follow the combiner, clear wipes them
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n)           res_q <= '0;
    else if (clear)        res_q <= '0;
    else if (result_valid) res_q <= result;
  end

  // Read decode
  always_comb begin
    rd_data = '0;
    rd_resp = OKAY;
    case (reg_addr_e'(axil_req.ar_addr))
      STATUS:              rd_data = WORD_WIDTH'({status.error, status.done,
                                                  status.ready, status.idle, 2'b00});
      LIBRARY_SIZE:        rd_data = WORD_WIDTH'(cfg.library_size);
      PIXEL_BANDS:         rd_data = WORD_WIDTH'(cfg.pixel_bands);
      CAPTURED_PIXEL_ADDR: rd_data = captured_pixel_addr;
      LIBRARY_PIXEL_ADDR:  rd_data = library_pixel_addr;
      MSE_MIN_REF:         rd_data = WORD_WIDTH'(res_q.min_ref);  // Zero-extended
      MSE_MIN_VALUE:       rd_data = res_q.min_value;
      MSE_MAX_REF:         rd_data = WORD_WIDTH'(res_q.max_ref);
      MSE_MAX_VALUE:       rd_data = res_q.max_value;
      default:             rd_resp = SLVERR;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      r_valid <= 1'b0;
      r_data  <= '0;
      r_resp  <= OKAY;
    end else if (axil_req.ar_valid && axil_rsp.ar_ready) begin
      r_valid <= 1'b1;
      r_data  <= rd_data;
      r_resp  <= rd_resp;
    end else if (r_valid && axil_req.r_ready) begin
      r_valid <= 1'b0;
    end
  end

  // Sequencer still idle when the pulse reaches it
  a_start_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
    start |-> status.idle);

  // Response held and unchanged while the master stalls
  a_b_hold: assert property (@(posedge clk) disable iff (!arst_n)
    axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid && $stable(axil_rsp.b_resp));

endmodule

// ==== logic/hsid_mse_combiner.sv ====
`timescale 1ns/1ps

module hsid_mse_combiner (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  logic                                        clear,
  input  logic [hsid_pkg::WORD_WIDTH-1:0]             even_sum,
  input  logic [hsid_pkg::WORD_WIDTH-1:0]             odd_sum,
  input  logic                                        sum_valid,
  input  logic [hsid_pkg::HSI_LIBRARY_SIZE_ADDR-1:0]  sum_ref,
  output hsid_pkg::mse_result_t                       result,
  output logic                                        result_valid
);
  import hsid_pkg::*;

  logic [WORD_WIDTH:0]   total_raw;
  logic [WORD_WIDTH-1:0] total;     // Saturated pixel distance
  logic                  first_pix;

  assign total_raw = {1'b0, even_sum} + odd_sum;
  assign total     = total_raw[WORD_WIDTH] ? '1 : total_raw[WORD_WIDTH-1:0];
  assign first_pix = (sum_ref == '0);  // Library index 0 opens a run

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result       <= '0;
      result_valid <= 1'b0;
    end else if (clear) begin
      result       <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= sum_valid;
      if (sum_valid) begin
        // Strict compare, ties keep the earlier reference
        if (first_pix || total < result.min_value) begin
          result.min_value <= total;
          result.min_ref   <= sum_ref;
        end
        if (first_pix || total > result.max_value) begin
          result.max_value <= total;
          result.max_ref   <= sum_ref;
        end
      end
    end
  end

endmodule

// ==== logic/hsid_pkg.sv ====
package hsid_pkg;

  localparam int WORD_WIDTH            = 32;                         // Register data width
  localparam int BAND_WIDTH            = 16;                         // One band sample
  localparam int HSI_BANDS             = 128;                        // Largest band count
  localparam int HSI_LIBRARY_SIZE      = 256;                        // Library capacity
  localparam int HSI_BANDS_ADDR        = $clog2(HSI_BANDS);          // 7 bits
  localparam int HSI_LIBRARY_SIZE_ADDR = $clog2(HSI_LIBRARY_SIZE);   // 8 bits
  localparam int AXIL_ADDR_WIDTH       = 6;                          // Byte address

  // Register byte offsets
  typedef enum logic [AXIL_ADDR_WIDTH-1:0] {
    STATUS              = 6'h00,
    LIBRARY_SIZE        = 6'h04,
    PIXEL_BANDS         = 6'h08,
    CAPTURED_PIXEL_ADDR = 6'h0C,
    LIBRARY_PIXEL_ADDR  = 6'h10,
    MSE_MIN_REF         = 6'h14,
    MSE_MIN_VALUE       = 6'h18,
    MSE_MAX_REF         = 6'h1C,
    MSE_MAX_VALUE       = 6'h20
  } reg_addr_e;

  typedef enum logic [2:0] {IDLE, RUN, DRAIN, DONE, ERROR} run_state_e;

  typedef enum logic [1:0] {OKAY = 2'b00, SLVERR = 2'b10} axil_resp_e;

  typedef struct packed {
    logic                       aw_valid;
    logic [AXIL_ADDR_WIDTH-1:0] aw_addr;
    logic                       w_valid;
    logic [WORD_WIDTH-1:0]      w_data;
    logic [WORD_WIDTH/8-1:0]    w_strb;
    logic                       b_ready;
    logic                       ar_valid;
    logic [AXIL_ADDR_WIDTH-1:0] ar_addr;
    logic                       r_ready;
  } axil_req_t;

  typedef struct packed {
    logic                  aw_ready;
    logic                  w_ready;
    logic                  b_valid;
    axil_resp_e            b_resp;
    logic                  ar_ready;
    logic                  r_valid;
    logic [WORD_WIDTH-1:0] r_data;
    axil_resp_e            r_resp;
  } axil_rsp_t;

  typedef struct packed {
    logic [HSI_LIBRARY_SIZE_ADDR-1:0] library_size;
    logic [HSI_BANDS_ADDR-1:0]        pixel_bands;
  } run_cfg_t;

  typedef struct packed {
    logic idle;
    logic ready;
    logic done;
    logic error;
  } run_status_t;

  // Two bands of captured and library pixel per beat
  typedef struct packed {
    logic [BAND_WIDTH-1:0] cap_even;
    logic [BAND_WIDTH-1:0] cap_odd;
    logic [BAND_WIDTH-1:0] lib_even;
    logic [BAND_WIDTH-1:0] lib_odd;
  } band_pair_t;

  typedef struct packed {
    logic                             valid;
    logic                             first;   // First beat of a pixel
    logic                             last;    // Last beat of a pixel
    logic [HSI_LIBRARY_SIZE_ADDR-1:0] lib_ref; // Library pixel index
  } lane_ctl_t;

  typedef struct packed {
    logic [HSI_LIBRARY_SIZE_ADDR-1:0] min_ref;
    logic [WORD_WIDTH-1:0]            min_value;
    logic [HSI_LIBRARY_SIZE_ADDR-1:0] max_ref;
    logic [WORD_WIDTH-1:0]            max_value;
  } mse_result_t;

endpackage

// ==== logic/hsid_sequencer.sv ====
`timescale 1ns/1ps

module hsid_sequencer (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   start,
  input  logic                   clear,
  input  hsid_pkg::run_cfg_t     cfg,
  output hsid_pkg::run_status_t  status,
  input  hsid_pkg::band_pair_t   sample,
  input  logic                   sample_valid,
  output logic                   sample_ready,
  output hsid_pkg::lane_ctl_t    lane_ctl,
  output hsid_pkg::band_pair_t   lane_sample
);
  import hsid_pkg::*;

  run_state_e                       state_q;
  logic [HSI_BANDS_ADDR-1:0]        beat_q;     // Beat within pixel
  logic [HSI_LIBRARY_SIZE_ADDR-1:0] pix_q;      // Pixel within library
  logic [1:0]                       drain_q;    // Pipeline drain count
  logic [HSI_BANDS_ADDR-1:0]        last_beat;
  logic                             beat_hs, pix_end, lib_end, cfg_bad;

  assign last_beat = (cfg.pixel_bands >> 1) - 1'b1;  // Two bands per beat
  assign cfg_bad   = (cfg.pixel_bands == '0) || cfg.pixel_bands[0] || (cfg.library_size == '0);

  assign sample_ready = (state_q == RUN);
  assign beat_hs      = sample_valid && sample_ready;
  assign pix_end      = (beat_q == last_beat);
  assign lib_end      = pix_end && (pix_q == cfg.library_size - 1'b1);

  // Tag the accepted beat for the lanes
  assign lane_ctl.valid   = beat_hs;
  assign lane_ctl.first   = (beat_q == '0);
  assign lane_ctl.last    = pix_end;
  assign lane_ctl.lib_ref = pix_q;
  assign lane_sample      = sample;

  assign status.idle  = (state_q == IDLE);
  assign status.ready = (state_q == RUN);
  assign status.done  = (state_q == DONE);
  assign status.error = (state_q == ERROR);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= IDLE;
      beat_q  <= '0;
      pix_q   <= '0;
      drain_q <= '0;
    end else if (clear) begin  // Any state back to idle
      state_q <= IDLE;
      beat_q  <= '0;
      pix_q   <= '0;
    end else begin
      case (state_q)
        IDLE: if (start) begin
          beat_q  <= '0;
          pix_q   <= '0;
          state_q <= cfg_bad ? ERROR : RUN;
        end
        RUN: if (beat_hs) begin
          beat_q <= pix_end ? '0 : beat_q + 1'b1;
          if (pix_end) pix_q <= pix_q + 1'b1;
          if (lib_end) begin
            state_q <= DRAIN;
            drain_q <= '0;
          end
        end
        DRAIN: begin  // Lane two stages plus combiner
          drain_q <= drain_q + 1'b1;
          if (drain_q == 2'd2) state_q <= DONE;
        end
        default: ;  // DONE and ERROR wait for clear
      endcase
    end
  end

  // Ready only inside RUN and within the configured pixel and library span
  a_ready_only_in_run: assert property (@(posedge clk) disable iff (!arst_n)
    sample_ready |-> (state_q == RUN) && (pix_q < cfg.library_size) && (beat_q <= last_beat));

endmodule

// ==== logic/hsid_sq_diff_lane.sv ====
`timescale 1ns/1ps

module hsid_sq_diff_lane (
  input  logic                                        clk,
  input  logic                                        arst_n,
  input  hsid_pkg::lane_ctl_t                         ctl,
  input  logic [hsid_pkg::BAND_WIDTH-1:0]             cap,
  input  logic [hsid_pkg::BAND_WIDTH-1:0]             lib,
  output logic [hsid_pkg::WORD_WIDTH-1:0]             sum,
  output logic                                        sum_valid,
  output logic [hsid_pkg::HSI_LIBRARY_SIZE_ADDR-1:0]  sum_ref
);
  import hsid_pkg::*;

  lane_ctl_t             ctl_q;     // Stage 1 tag
  logic [BAND_WIDTH-1:0] diff_q;    // Stage 1 absolute difference
  logic [WORD_WIDTH-1:0] sq, base;
  logic [WORD_WIDTH:0]   acc_next;  // One carry bit for saturation

  assign sq       = diff_q * diff_q;             // 16x16 fits the word
  assign base     = ctl_q.first ? '0 : sum;      // Restart on new pixel
  assign acc_next = {1'b0, base} + sq;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctl_q     <= '0;
      sum_valid <= 1'b0;
    end else begin
      ctl_q     <= ctl;
      sum_valid <= ctl_q.valid && ctl_q.last;  // Pixel sum complete
    end
  end

  always_ff @(posedge clk) begin
    diff_q <= (cap > lib) ? cap - lib : lib - cap;
    if (ctl_q.valid) begin
      sum     <= acc_next[WORD_WIDTH] ? '1 : acc_next[WORD_WIDTH-1:0];
      sum_ref <= ctl_q.lib_ref;
    end
  end

endmodule

// ==== logic/hsid_top.sv ====
`timescale 1ns/1ps

module hsid_top (
  input  logic                             clk,
  input  logic                             arst_n,
  input  hsid_pkg::axil_req_t              axil_req,
  output hsid_pkg::axil_rsp_t              axil_rsp,
  input  hsid_pkg::band_pair_t             sample,
  input  logic                             sample_valid,
  output logic                             sample_ready,
  output logic [hsid_pkg::WORD_WIDTH-1:0]  captured_pixel_addr,
  output logic [hsid_pkg::WORD_WIDTH-1:0]  library_pixel_addr
);
  import hsid_pkg::*;

  logic                             start, clear;
  run_cfg_t                         cfg;
  run_status_t                      status;
  lane_ctl_t                        lane_ctl;
  band_pair_t                       lane_sample;
  logic [WORD_WIDTH-1:0]            even_sum, odd_sum;
  logic                             even_valid, odd_valid;
  logic [HSI_LIBRARY_SIZE_ADDR-1:0] even_ref, odd_ref;
  mse_result_t                      result;
  logic                             result_valid;

  hsid_ctrl_reg ctrl_reg_i (
    .clk                 (clk),
    .arst_n              (arst_n),
    .axil_req            (axil_req),
    .axil_rsp            (axil_rsp),
    .start               (start),
    .clear               (clear),
    .cfg                 (cfg),
    .captured_pixel_addr (captured_pixel_addr),
    .library_pixel_addr  (library_pixel_addr),
    .status              (status),
    .result              (result),
    .result_valid        (result_valid)
  );

  hsid_sequencer sequencer_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .start        (start),
    .clear        (clear),
    .cfg          (cfg),
    .status       (status),
    .sample       (sample),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .lane_ctl     (lane_ctl),
    .lane_sample  (lane_sample)
  );

  // Even bands
  hsid_sq_diff_lane lane_even_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .ctl       (lane_ctl),
    .cap       (lane_sample.cap_even),
    .lib       (lane_sample.lib_even),
    .sum       (even_sum),
    .sum_valid (even_valid),
    .sum_ref   (even_ref)
  );

  // Odd bands
  hsid_sq_diff_lane lane_odd_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .ctl       (lane_ctl),
    .cap       (lane_sample.cap_odd),
    .lib       (lane_sample.lib_odd),
    .sum       (odd_sum),
    .sum_valid (odd_valid),
    .sum_ref   (odd_ref)
  );

  hsid_mse_combiner combiner_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .clear        (clear),
    .even_sum     (even_sum),
    .odd_sum      (odd_sum),
    .sum_valid    (even_valid),  // Lanes run in lockstep
    .sum_ref      (even_ref),
    .result       (result),
    .result_valid (result_valid)
  );

  // Lanes agree and keep the two-stage latency the drain count relies on
  a_lanes_in_step: assert property (@(posedge clk) disable iff (!arst_n)
    (even_valid == odd_valid) && (!even_valid || even_ref == odd_ref) &&
    (even_valid == $past(lane_ctl.valid && lane_ctl.last, 2)));

endmodule

// ==== tb/hsid_tb_axil.svh ====
// AXI4-Lite write, address and data offered together
task automatic axil_write(input logic [AXIL_ADDR_WIDTH-1:0] addr,
                          input logic [WORD_WIDTH-1:0] data, output axil_resp_e resp);
  logic aw_hs, w_hs;
  axil_req.aw_valid = 1'b1;
  axil_req.aw_addr  = addr;
  axil_req.w_valid  = 1'b1;
  axil_req.w_data   = data;
  axil_req.w_strb   = '1;
  axil_req.b_ready  = 1'b1;
  while (axil_req.aw_valid || axil_req.w_valid) begin
    @(negedge clk);  // Handshake settled before the edge
    aw_hs = axil_req.aw_valid && axil_rsp.aw_ready;
    w_hs  = axil_req.w_valid && axil_rsp.w_ready;
    @(posedge clk);
    #1;
    if (aw_hs) axil_req.aw_valid = 1'b0;
    if (w_hs)  axil_req.w_valid  = 1'b0;
  end
  @(negedge clk);
  while (!axil_rsp.b_valid) @(negedge clk);
  resp = axil_rsp.b_resp;
  @(posedge clk);  // B accepted here
  #1;
  axil_req.b_ready = 1'b0;
endtask

task automatic axil_read(input logic [AXIL_ADDR_WIDTH-1:0] addr,
                         output logic [WORD_WIDTH-1:0] data, output axil_resp_e resp);
  axil_req.ar_valid = 1'b1;
  axil_req.ar_addr  = addr;
  axil_req.r_ready  = 1'b1;
  @(negedge clk);
  while (!axil_rsp.ar_ready) @(negedge clk);
  @(posedge clk);
  #1;
  axil_req.ar_valid = 1'b0;
  @(negedge clk);
  while (!axil_rsp.r_valid) @(negedge clk);
  data = axil_rsp.r_data;
  resp = axil_rsp.r_resp;
  @(posedge clk);
  #1;
  axil_req.r_ready = 1'b0;
endtask

task automatic check_word(input string name, input logic [WORD_WIDTH-1:0] got,
                          input logic [WORD_WIDTH-1:0] want);
  if (got !== want)
    fail_stop($sformatf("ERROR %0t %s got %h expected %h", $time, name, got, want));
endtask

task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e want);
  if (got !== want)
    fail_stop($sformatf("ERROR %0t %s got %s expected %s", $time, name, got.name(),
                        want.name()));
endtask

task automatic check_result(input string name, input mse_result_t got, input mse_result_t want);
  if (got !== want)
    fail_stop($sformatf("ERROR %0t %s got min %h@%0d max %h@%0d expected min %h@%0d max %h@%0d",
                        $time, name, got.min_value, got.min_ref, got.max_value, got.max_ref,
                        want.min_value, want.min_ref, want.max_value, want.max_ref));
endtask

// ==== tb/hsid_tb.sv ====
`timescale 1ns/1ps

module hsid_tb;
  import hsid_pkg::*;

  localparam int NUM_ROWS      = 9;
  localparam int ACCESS_CYCLES = 12;  // Worst bus access plus margin
  localparam int ACCESSES_ROW  = 24;
  localparam int STALL_FACTOR  = 4;   // Beats stretched by random stalls

  typedef struct packed {
    int         lib_size;
    int         bands;
    logic [7:0] stall_mask;  // Set bit stalls on a 3-bit random pick
    int         width;       // Sample bits drawn per band
    logic       dup;         // Library pixels repeat in pairs
    logic       exp_err;     // Setup must be rejected
  } run_row_t;

  logic                  clk;
  logic                  arst_n;
  axil_req_t             axil_req;
  axil_rsp_t             axil_rsp;
  band_pair_t            sample;
  logic                  sample_valid;
  logic                  sample_ready;
  logic [WORD_WIDTH-1:0] captured_pixel_addr, library_pixel_addr;

  run_row_t              rows [NUM_ROWS];
  logic [15:0]           lfsr_q = 16'd52;
  logic [BAND_WIDTH-1:0] cap_px [HSI_BANDS];                   // Captured pixel
  logic [BAND_WIDTH-1:0] lib_px [HSI_LIBRARY_SIZE*HSI_BANDS];  // Library, pixel major
  int                    cycles = 0;
  int                    cycle_limit = 0;

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  `include "hsid_tb_axil.svh"

  hsid_top dut_i (
    .clk                 (clk),
    .arst_n              (arst_n),
    .axil_req            (axil_req),
    .axil_rsp            (axil_rsp),
    .sample              (sample),
    .sample_valid        (sample_valid),
    .sample_ready        (sample_ready),
    .captured_pixel_addr (captured_pixel_addr),
    .library_pixel_addr  (library_pixel_addr)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit)
      fail_stop($sformatf("Timeout after %0d cycles, the DUT stopped making progress", cycles));
  end

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        b;
    val = '0;
    for (int i = 0; i < n; i++) begin
      b      = lfsr_q[0];
      lfsr_q = (lfsr_q >> 1) ^ (b ? 16'hB400 : 16'h0000);
      val    = {val[30:0], b};
    end
    return val;
  endfunction

  task automatic fill_table();
    rows[0] = '{4, 8, 8'h00, 12, 1'b0, 1'b0};
    rows[1] = '{6, 16, 8'h5A, 12, 1'b0, 1'b0};
    rows[2] = '{5, 4, 8'hF0, 12, 1'b1, 1'b0};    // Ties between repeated pixels
    rows[3] = '{3, 64, 8'h11, 16, 1'b0, 1'b0};   // Full range, sums saturate
    rows[4] = '{2, 2, 8'h00, 12, 1'b0, 1'b0};    // One beat per pixel
    rows[5] = '{1, 126, 8'h33, 16, 1'b0, 1'b0};
    rows[6] = '{3, 5, 8'h00, 12, 1'b0, 1'b1};    // Odd band count
    rows[7] = '{0, 8, 8'h00, 12, 1'b0, 1'b1};    // Empty library
    rows[8] = '{4, 0, 8'h00, 12, 1'b0, 1'b1};    // No bands
  endtask

  function automatic int run_limit();
    int beats;
    beats = 0;
    for (int r = 0; r < NUM_ROWS; r++) beats += rows[r].lib_size * rows[r].bands / 2;
    return 8 + STALL_FACTOR * beats + (NUM_ROWS + 2) * ACCESSES_ROW * ACCESS_CYCLES;
  endfunction

  task automatic make_pixels(input run_row_t row);
    for (int b = 0; b < row.bands; b++) cap_px[b] = BAND_WIDTH'(rand_bits(row.width));
    for (int p = 0; p < row.lib_size; p++) begin
      for (int b = 0; b < row.bands; b++) begin
        lib_px[p*row.bands + b] = (row.dup && p >= 2) ? lib_px[(p % 2)*row.bands + b]
                                                       : BAND_WIDTH'(rand_bits(row.width));
      end
    end
  endtask

  // Saturating squared distance per lane, then per pixel, earlier pixel wins ties
  function automatic mse_result_t model_result(input run_row_t row);
    mse_result_t           want;
    logic [WORD_WIDTH:0]   part [2];
    logic [WORD_WIDTH:0]   both;
    logic [WORD_WIDTH-1:0] total, d;
    want = '0;
    for (int p = 0; p < row.lib_size; p++) begin
      part[0] = '0;
      part[1] = '0;
      for (int b = 0; b < row.bands; b++) begin
        d = (cap_px[b] > lib_px[p*row.bands + b]) ? cap_px[b] - lib_px[p*row.bands + b]
                                                  : lib_px[p*row.bands + b] - cap_px[b];
        part[b % 2] = part[b % 2] + d * d;
        if (part[b % 2][WORD_WIDTH]) part[b % 2] = {1'b0, {WORD_WIDTH{1'b1}}};
      end
      both  = part[0] + part[1];
      total = both[WORD_WIDTH] ? '1 : both[WORD_WIDTH-1:0];
      if (p == 0 || total < want.min_value) begin
        want.min_value = total;
        want.min_ref   = p;
      end
      if (p == 0 || total > want.max_value) begin
        want.max_value = total;
        want.max_ref   = p;
      end
    end
    return want;
  endfunction

  task automatic write_expect(input logic [AXIL_ADDR_WIDTH-1:0] addr,
                              input logic [WORD_WIDTH-1:0] data, input axil_resp_e want,
                              input string name);
    axil_resp_e resp;
    axil_write(addr, data, resp);
    check_resp({name, " bresp"}, resp, want);
  endtask

  task automatic read_word(input logic [AXIL_ADDR_WIDTH-1:0] addr,
                           output logic [WORD_WIDTH-1:0] data);
    axil_resp_e resp;
    axil_read(addr, data, resp);
    check_resp("rresp", resp, OKAY);
  endtask

  task automatic read_expect(input logic [AXIL_ADDR_WIDTH-1:0] addr,
                             input logic [WORD_WIDTH-1:0] want, input string name);
    logic [WORD_WIDTH-1:0] data;
    read_word(addr, data);
    check_word(name, data, want);
  endtask

  task automatic check_config_regs();
    write_expect(LIBRARY_SIZE, 32'd200, OKAY, "LIBRARY_SIZE");
    write_expect(PIXEL_BANDS, 32'd96, OKAY, "PIXEL_BANDS");
    write_expect(CAPTURED_PIXEL_ADDR, 32'h8000_1000, OKAY, "CAPTURED_PIXEL_ADDR");
    write_expect(LIBRARY_PIXEL_ADDR, 32'h9000_2A00, OKAY, "LIBRARY_PIXEL_ADDR");
    read_expect(LIBRARY_SIZE, 32'd200, "LIBRARY_SIZE");
    read_expect(PIXEL_BANDS, 32'd96, "PIXEL_BANDS");
    read_expect(CAPTURED_PIXEL_ADDR, 32'h8000_1000, "CAPTURED_PIXEL_ADDR");
    read_expect(LIBRARY_PIXEL_ADDR, 32'h9000_2A00, "LIBRARY_PIXEL_ADDR");
    check_word("captured_pixel_addr", captured_pixel_addr, 32'h8000_1000);
    check_word("library_pixel_addr", library_pixel_addr, 32'h9000_2A00);
  endtask

  task automatic check_protected_writes();
    logic [WORD_WIDTH-1:0] data;
    axil_resp_e            resp;
    write_expect(6'h24, 32'hFFFF_FFFF, SLVERR, "unknown offset");
    axil_read(6'h24, data, resp);
    check_resp("unknown offset rresp", resp, SLVERR);
    check_word("unknown offset rdata", data, '0);
    write_expect(STATUS, 32'h3C, OKAY, "STATUS read-only bits");  // No start, no clear
    read_expect(STATUS, 32'h4, "STATUS");
    write_expect(MSE_MAX_VALUE, 32'h1234_5678, OKAY, "MSE_MAX_VALUE");
    read_expect(MSE_MAX_VALUE, '0, "MSE_MAX_VALUE");
  endtask

  task automatic drive_stream(input run_row_t row);
    int   beat, half, p, b;
    logic hs;
    beat = 0;
    half = row.bands / 2;
    while (beat < row.lib_size * half) begin
      p = beat / half;
      b = 2 * (beat % half);
      sample.cap_even = cap_px[b];
      sample.cap_odd  = cap_px[b + 1];
      sample.lib_even = lib_px[p*row.bands + b];
      sample.lib_odd  = lib_px[p*row.bands + b + 1];
      sample_valid    = !row.stall_mask[rand_bits(3)];
      @(negedge clk);
      hs = sample_valid && sample_ready;
      @(posedge clk);
      #1;
      if (hs) beat++;
    end
    sample_valid = 1'b0;
  endtask

  task automatic wait_done();
    logic [WORD_WIDTH-1:0] st;
    st = '0;
    while (!st[4]) begin
      read_word(STATUS, st);
      if (st[5]) fail_stop("Run entered the error state with a valid configuration");
    end
  endtask

  task automatic run_good(input run_row_t row);
    mse_result_t           want, got;
    logic [WORD_WIDTH-1:0] word;
    make_pixels(row);
    want = model_result(row);
    write_expect(LIBRARY_SIZE, row.lib_size, OKAY, "LIBRARY_SIZE");
    write_expect(PIXEL_BANDS, row.bands, OKAY, "PIXEL_BANDS");
    write_expect(STATUS, 32'h1, OKAY, "STATUS start");
    fork
      drive_stream(row);
      begin
        // Locked while busy
        write_expect(LIBRARY_SIZE, row.lib_size + 1, SLVERR, "LIBRARY_SIZE while busy");
        wait_done();
      end
    join
    read_expect(LIBRARY_SIZE, row.lib_size, "LIBRARY_SIZE after busy write");
    read_word(MSE_MIN_REF, word);
    check_word("MSE_MIN_REF upper bits", word >> HSI_LIBRARY_SIZE_ADDR, '0);
    got.min_ref = word[HSI_LIBRARY_SIZE_ADDR-1:0];
    read_word(MSE_MIN_VALUE, got.min_value);
    read_word(MSE_MAX_REF, word);
    check_word("MSE_MAX_REF upper bits", word >> HSI_LIBRARY_SIZE_ADDR, '0);
    got.max_ref = word[HSI_LIBRARY_SIZE_ADDR-1:0];
    read_word(MSE_MAX_VALUE, got.max_value);
    check_result("MSE result", got, want);
  endtask

  task automatic run_bad(input run_row_t row);
    write_expect(LIBRARY_SIZE, row.lib_size, OKAY, "LIBRARY_SIZE");
    write_expect(PIXEL_BANDS, row.bands, OKAY, "PIXEL_BANDS");
    write_expect(STATUS, 32'h1, OKAY, "STATUS start");
    read_expect(STATUS, 32'h20, "STATUS after bad start");  // Error only
    @(negedge clk);
    check_word("sample_ready", WORD_WIDTH'(sample_ready), '0);
    @(posedge clk);
    #1;
  endtask

  task automatic clear_and_check();
    write_expect(STATUS, 32'h2, OKAY, "STATUS clear");
    read_expect(STATUS, 32'h4, "STATUS after clear");
    read_expect(MSE_MIN_REF, '0, "MSE_MIN_REF after clear");
    read_expect(MSE_MIN_VALUE, '0, "MSE_MIN_VALUE after clear");
    read_expect(MSE_MAX_REF, '0, "MSE_MAX_REF after clear");
    read_expect(MSE_MAX_VALUE, '0, "MSE_MAX_VALUE after clear");
  endtask

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    axil_req     = '0;
    sample       = '0;
    sample_valid = 1'b0;
    fill_table();
    cycle_limit = run_limit();
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_config_regs();
    check_protected_writes();
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].exp_err) run_bad(rows[r]);
      else run_good(rows[r]);
      clear_and_check();
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
